// File: Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing -j 0
TOP      ?= klClockTb
FILELIST ?= sim.f
OBJDIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only if the run prints the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(OBJDIR)

// File: hw/clockConfigRegs.sv
`timescale 1ns/1ps

module clockConfigRegs (
  input logic MBOX_CLK,
  input logic CLK,
  diagCmdIf.receiver cmd,
  clockCfgIf.source cfg
);

  klClockPkg::diagWord_u loadWord;

  // Data word of the current load cycle
  assign loadWord = cmd.wrWord;

  // Rate select register
  // Low two bits of the word, other bits ignored
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      cfg.rateSel <= '0;
    end else if (cmd.ldRate) begin
      cfg.rateSel <= loadWord.rate.rateSel;
    end
  end

  // Domain disable register
  // Bit 0 control, bit 1 data path, bit 2 microcode
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      cfg.crmDis <= 1'b0;
      cfg.edpDis <= 1'b0;
      cfg.ctlDis <= 1'b0;
    end else if (cmd.ldDisable) begin
      cfg.crmDis <= loadWord.dis.crmDis;
      cfg.edpDis <= loadWord.dis.edpDis;
      cfg.ctlDis <= loadWord.dis.ctlDis;
    end
  end

endmodule

// File: hw/diagBusSlave.sv
`timescale 1ns/1ps

module diagBusSlave (
  input  logic MBOX_CLK,
  input  logic CLK,
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbWe,
  input  logic [klClockPkg::adrWidth-1:0] wbAdr,
  input  logic [klClockPkg::dataWidth-1:0] wbDatW,
  output logic [klClockPkg::dataWidth-1:0] wbDatR,
  output logic wbAck,
  diagCmdIf.driver cmd,
  clockCfgIf.reader cfg,
  clockStatIf.reader stat
);

  logic isLoad;
  logic wrAcc;
  logic [klClockPkg::funcWidth-1:0] funcCode;

  // Bit 3 picks load codes over control codes
  assign isLoad = wbAdr[klClockPkg::adrWidth-1];
  assign funcCode = wbAdr[klClockPkg::funcWidth-1:0];

  // Write takes effect in the ack cycle only
  assign wrAcc = wbAck & wbCyc & wbStb & wbWe;

  // One ack per cycle, then at least one idle cycle
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= wbCyc & wbStb & ~wbAck;
    end
  end

  assign cmd.wrWord = wbDatW;

  // Function strobe decoder
  always_comb begin
    cmd.start = 1'b0;
    cmd.singleStep = 1'b0;
    cmd.burst = 1'b0;
    cmd.clrReset = 1'b0;
    cmd.setReset = 1'b0;
    cmd.ldBurstLsb = 1'b0;
    cmd.ldBurstMsb = 1'b0;
    cmd.ldRate = 1'b0;
    cmd.ldDisable = 1'b0;
    if (wrAcc && !isLoad) begin
      case (funcCode)
        klClockPkg::funcStart: cmd.start = 1'b1;
        klClockPkg::funcSingleStep: cmd.singleStep = 1'b1;
        klClockPkg::funcBurst: cmd.burst = 1'b1;
        klClockPkg::funcClrReset: cmd.clrReset = 1'b1;
        klClockPkg::funcSetReset: cmd.setReset = 1'b1;
        default: ;
      endcase
    end else if (wrAcc) begin
      case (funcCode)
        klClockPkg::ldBurstLsb: cmd.ldBurstLsb = 1'b1;
        klClockPkg::ldBurstMsb: cmd.ldBurstMsb = 1'b1;
        klClockPkg::ldRate: cmd.ldRate = 1'b1;
        klClockPkg::ldDisable: cmd.ldDisable = 1'b1;
        default: ;
      endcase
    end
  end

  // Status read mux, load addresses read as zero
  always_comb begin
    wbDatR = '0;
    if (!isLoad) begin
      case (funcCode)
        klClockPkg::rdBurst: wbDatR = stat.burstCount;
        klClockPkg::rdStatus: begin
          wbDatR[0] = stat.running;
          wbDatR[1] = stat.bursting;
          wbDatR[2] = stat.mrReset;
          wbDatR[3] = stat.eboxSync;
        end
        klClockPkg::rdConfig: begin
          // Same bit layout as the disable load word
          wbDatR[2:0] = {cfg.crmDis, cfg.edpDis, cfg.ctlDis};
          wbDatR[5:4] = cfg.rateSel;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hw/eboxSyncCtl.sv
`timescale 1ns/1ps

module eboxSyncCtl (
  input  logic MBOX_CLK,
  input  logic CLK,
  input  logic tickReq,
  input  logic [klClockPkg::timeWidth-1:0] timeField,
  clockCfgIf.reader cfg,
  clockStatIf.sync stat,
  output logic crmClk,
  output logic edpClk,
  output logic ctlClk
);

  logic pending;
  logic [klClockPkg::timeWidth-1:0] phaseCnt;
  logic phaseMet;

  // Tick requests merge into one pending flag
  // A request in the clock cycle itself is kept for the next clock
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      pending <= 1'b0;
    end else begin
      pending <= tickReq | (pending & ~stat.eboxClk);
    end
  end

  // MBOX cycles since the last processor clock, saturating
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      phaseCnt <= '0;
    end else if (stat.eboxClk) begin
      phaseCnt <= '0;
    end else if (phaseCnt != '1) begin
      phaseCnt <= phaseCnt + 1'b1;
    end
  end

  // Sync point reached once the microcode time field is met
  assign phaseMet = phaseCnt >= timeField;

  // Sync point, one MBOX cycle ahead of the processor clock
  // Held off by master reset and by the clock cycle itself
  assign stat.eboxSync = pending & phaseMet & ~stat.mrReset & ~stat.eboxClk;

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      stat.eboxClk <= 1'b0;
    end else begin
      stat.eboxClk <= stat.eboxSync;
    end
  end

  // Per-domain clock enables
  assign crmClk = stat.eboxClk & ~cfg.crmDis;
  assign edpClk = stat.eboxClk & ~cfg.edpDis;
  assign ctlClk = stat.eboxClk & ~cfg.ctlDis;

endmodule

// File: hw/klClockIf.sv
`timescale 1ns/1ps

// Decoded diagnostic functions, one MBOX cycle wide
interface diagCmdIf;
  logic start;
  logic singleStep;
  logic burst;
  logic clrReset;
  logic setReset;
  logic ldBurstLsb;
  logic ldBurstMsb;
  logic ldRate;
  logic ldDisable;
  // Write data that goes with the load strobes
  klClockPkg::diagWord_u wrWord;

  modport driver (
    output start, singleStep, burst, clrReset, setReset,
    output ldBurstLsb, ldBurstMsb, ldRate, ldDisable, wrWord
  );

  modport receiver (
    input start, singleStep, burst, clrReset, setReset,
    input ldBurstLsb, ldBurstMsb, ldRate, ldDisable, wrWord
  );
endinterface

// Rate and domain-disable configuration
interface clockCfgIf;
  logic [klClockPkg::rateWidth-1:0] rateSel;
  logic crmDis;
  logic edpDis;
  logic ctlDis;

  modport source (output rateSel, crmDis, edpDis, ctlDis);
  modport reader (input rateSel, crmDis, edpDis, ctlDis);
endinterface

// Run state and processor clock status
interface clockStatIf;
  logic running;
  logic bursting;
  logic [klClockPkg::burstWidth-1:0] burstCount;
  logic mrReset;
  logic eboxSync;
  logic eboxClk;

  // Run control owns the run state, watches returned clocks
  modport run (output running, bursting, burstCount, mrReset, input eboxClk);
  // Sync detector owns the processor clock, held off by master reset
  modport sync (output eboxSync, eboxClk, input mrReset);
  modport reader (input running, bursting, burstCount, mrReset, eboxSync, eboxClk);
endinterface

// File: hw/klClockPkg.sv
package klClockPkg;

  // Wishbone word and address widths
  localparam int dataWidth = 8;
  localparam int adrWidth = 4;

  // Low address bits carry the function code or status index
  localparam int funcWidth = 3;

  // Control functions, address bit 3 low, write
  localparam logic [funcWidth-1:0] funcStart = 3'd1;
  localparam logic [funcWidth-1:0] funcSingleStep = 3'd2;
  localparam logic [funcWidth-1:0] funcBurst = 3'd5;
  localparam logic [funcWidth-1:0] funcClrReset = 3'd6;
  localparam logic [funcWidth-1:0] funcSetReset = 3'd7;

  // Register loads, address bit 3 high, write
  localparam logic [funcWidth-1:0] ldBurstLsb = 3'd2;
  localparam logic [funcWidth-1:0] ldBurstMsb = 3'd3;
  localparam logic [funcWidth-1:0] ldRate = 3'd4;
  localparam logic [funcWidth-1:0] ldDisable = 3'd5;

  // Status words, address bit 3 low, read
  localparam logic [funcWidth-1:0] rdBurst = 3'd0;
  localparam logic [funcWidth-1:0] rdStatus = 3'd1;
  localparam logic [funcWidth-1:0] rdConfig = 3'd2;

  // Burst counter, loaded one nibble at a time
  localparam int burstWidth = 8;
  localparam int nibbleWidth = burstWidth / 2;

  // Rate select and microcode time field
  localparam int rateWidth = 2;
  localparam int timeWidth = 2;

  // Rate divider spans up to 2**3 MBOX cycles
  localparam int divWidth = (1 << rateWidth) - 1;

  // One written diagnostic word, seen three ways
  typedef union packed {
    // Burst counter nibble
    struct packed {
      logic [dataWidth-nibbleWidth-1:0] spare;
      logic [nibbleWidth-1:0] value;
    } nib;
    // Processor clock rate
    struct packed {
      logic [dataWidth-rateWidth-1:0] spare;
      logic [rateWidth-1:0] rateSel;
    } rate;
    // Domain clock disables
    struct packed {
      logic [dataWidth-4:0] spare;
      logic crmDis;
      logic edpDis;
      logic ctlDis;
    } dis;
  } diagWord_u;

endpackage

// File: hw/klClockTop.sv
`timescale 1ns/1ps

module klClockTop (
  input  logic MBOX_CLK,
  input  logic CLK,
  // Diagnostic bus, Wishbone classic
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbWe,
  input  logic [klClockPkg::adrWidth-1:0] wbAdr,
  input  logic [klClockPkg::dataWidth-1:0] wbDatW,
  output logic [klClockPkg::dataWidth-1:0] wbDatR,
  output logic wbAck,
  // Microcode time field of the current instruction
  input  logic [klClockPkg::timeWidth-1:0] timeField,
  // Processor clock outputs
  output logic eboxSync,
  output logic eboxClk,
  output logic crmClk,
  output logic edpClk,
  output logic ctlClk,
  output logic mrReset
);

  diagCmdIf cmdBus ();
  clockCfgIf cfgBus ();
  clockStatIf statBus ();

  logic tickReq;

  diagBusSlave slave (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbWe     (wbWe),
    .wbAdr    (wbAdr),
    .wbDatW   (wbDatW),
    .wbDatR   (wbDatR),
    .wbAck    (wbAck),
    .cmd      (cmdBus.driver),
    .cfg      (cfgBus.reader),
    .stat     (statBus.reader)
  );

  clockConfigRegs cfgRegs (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .cmd      (cmdBus.receiver),
    .cfg      (cfgBus.source)
  );

  runControl runCtl (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .cmd      (cmdBus.receiver),
    .cfg      (cfgBus.reader),
    .stat     (statBus.run),
    .tickReq  (tickReq)
  );

  eboxSyncCtl syncCtl (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .tickReq   (tickReq),
    .timeField (timeField),
    .cfg       (cfgBus.reader),
    .stat      (statBus.sync),
    .crmClk    (crmClk),
    .edpClk    (edpClk),
    .ctlClk    (ctlClk)
  );

  assign eboxSync = statBus.eboxSync;
  assign eboxClk = statBus.eboxClk;
  assign mrReset = statBus.mrReset;

endmodule

// File: hw/runControl.sv
`timescale 1ns/1ps

module runControl (
  input  logic MBOX_CLK,
  input  logic CLK,
  diagCmdIf.receiver cmd,
  clockCfgIf.reader cfg,
  clockStatIf.run stat,
  output logic tickReq
);

  logic [klClockPkg::divWidth-1:0] divCnt;
  logic [klClockPkg::divWidth-1:0] rateMask;
  logic rateTick;
  logic countNz;
  logic lastCount;
  logic active;
  logic stopAll;

  assign countNz = |stat.burstCount;
  assign lastCount = (stat.burstCount[klClockPkg::burstWidth-1:1] == '0) & stat.burstCount[0];

  // Single step and both reset functions halt run and burst
  assign stopAll = cmd.singleStep | cmd.clrReset | cmd.setReset;

  // Rate divider, restarted by every processor clock
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      divCnt <= '0;
    end else if (stat.eboxClk) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // Mask of 2**rateSel - 1
  assign rateMask = ~({klClockPkg::divWidth{1'b1}} << cfg.rateSel);
  assign rateTick = (divCnt & rateMask) == rateMask;

  assign active = stat.running | (stat.bursting & countNz);

  // No rate tick in a processor clock cycle, so a finished burst stops clean
  assign tickReq = cmd.singleStep | (rateTick & active & ~stat.eboxClk);

  // Run, burst and master-reset state
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      stat.running <= 1'b0;
      stat.bursting <= 1'b0;
      stat.mrReset <= 1'b1;
    end else begin
      if (cmd.start) begin
        stat.running <= 1'b1;
      end
      // Burst ends on the last returned clock or an emptied count
      if (stat.bursting && (!countNz || (stat.eboxClk && lastCount))) begin
        stat.bursting <= 1'b0;
      end
      if (cmd.burst && countNz) begin
        stat.bursting <= 1'b1;
      end
      if (stopAll) begin
        stat.running <= 1'b0;
        stat.bursting <= 1'b0;
      end
      if (cmd.clrReset) begin
        stat.mrReset <= 1'b0;
      end
      if (cmd.setReset) begin
        stat.mrReset <= 1'b1;
      end
    end
  end

  // Burst counter
  // Nibble loads win over the countdown
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      stat.burstCount <= '0;
    end else if (cmd.ldBurstLsb) begin
      stat.burstCount[klClockPkg::nibbleWidth-1:0] <= cmd.wrWord.nib.value;
    end else if (cmd.ldBurstMsb) begin
      stat.burstCount[klClockPkg::burstWidth-1:klClockPkg::nibbleWidth] <=
        cmd.wrWord.nib.value;
    end else if (stat.bursting && stat.eboxClk && countNz) begin
      stat.burstCount <= stat.burstCount - 1'b1;
    end
  end

endmodule

// File: sim.f
hw/klClockPkg.sv
hw/klClockIf.sv
hw/diagBusSlave.sv
hw/clockConfigRegs.sv
hw/runControl.sv
hw/eboxSyncCtl.sv
hw/klClockTop.sv
verif/klClockChecker.sv
verif/klClockTb.sv

// File: verif/klClockChecker.sv
`timescale 1ns/1ps

module klClockChecker (
  input logic MBOX_CLK,
  input logic CLK,
  input logic eboxSync,
  input logic eboxClk,
  input logic crmClk,
  input logic edpClk,
  input logic ctlClk
);

  // Running totals, never cleared between tests
  int cycle = 0;
  int clkTotal = 0;
  int crmTotal = 0;
  int edpTotal = 0;
  int ctlTotal = 0;
  int lastClkCycle = 0;
  int seqErrs = 0;
  int valErrs = 0;
  logic prevSync = 1'b0;

  // Snapshot taken when a test begins
  string testName = "";
  int testStart = 0;
  int expMinGap = 0;
  int clkBase = 0;
  int crmBase = 0;
  int edpBase = 0;
  int ctlBase = 0;
  int errBase = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int checks = 0;

  // Pulse counting, sync pairing and spacing, sampled before each edge
  always @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      cycle = 0;
      prevSync = 1'b0;
    end else begin
      cycle = cycle + 1;
      if (eboxClk) begin
        clkTotal = clkTotal + 1;
        if (!prevSync) begin
          seqErrs = seqErrs + 1;
          $display("FAIL %0t: eboxClk without eboxSync in the prior cycle", $time);
        end
        // Spacing is only judged between two pulses of the same test
        if (lastClkCycle > testStart && cycle - lastClkCycle < expMinGap) begin
          seqErrs = seqErrs + 1;
          $display("FAIL %0t: eboxClk gap of %0d cycles, at least %0d expected",
                   $time, cycle - lastClkCycle, expMinGap);
        end
        lastClkCycle = cycle;
      end
      if (crmClk) crmTotal = crmTotal + 1;
      if (edpClk) edpTotal = edpTotal + 1;
      if (ctlClk) ctlTotal = ctlTotal + 1;
      prevSync = eboxSync;
    end
  end

  task automatic beginTest(input string name, input int minGap);
    testName = name;
    testStart = cycle;
    expMinGap = minGap;
    clkBase = clkTotal;
    crmBase = crmTotal;
    edpBase = edpTotal;
    ctlBase = ctlTotal;
    errBase = seqErrs + valErrs;
  endtask

  function automatic int clkSince();
    return clkTotal - clkBase;
  endfunction

  function automatic int errorTotal();
    return seqErrs + valErrs;
  endfunction

  task automatic checkValue(input string what, input int got, input int exp);
    checks = checks + 1;
    if (got != exp) begin
      valErrs = valErrs + 1;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkAtMost(input string what, input int got, input int limit);
    checks = checks + 1;
    if (got > limit) begin
      valErrs = valErrs + 1;
      $display("FAIL %0t: %s is %0d, at most %0d expected", $time, what, got, limit);
    end
  endtask

  // Pulse counts of the processor clock and the three domains
  task automatic checkPulses(input int expClk, input int expCrm, input int expEdp,
                             input int expCtl);
    checkValue("eboxClk pulses", clkTotal - clkBase, expClk);
    checkValue("crmClk pulses", crmTotal - crmBase, expCrm);
    checkValue("edpClk pulses", edpTotal - edpBase, expEdp);
    checkValue("ctlClk pulses", ctlTotal - ctlBase, expCtl);
  endtask

  task automatic endTest();
    int errs;
    errs = seqErrs + valErrs - errBase;
    testsRun = testsRun + 1;
    if (errs == 0) begin
      $display("test %s: passed", testName);
    end else begin
      testsFailed = testsFailed + 1;
      $display("test %s: failed with %0d errors", testName, errs);
    end
  endtask

endmodule

// File: verif/klClockTb.sv
`timescale 1ns/1ps

module klClockTb;

  logic MBOX_CLK;
  logic CLK;
  logic wbCyc;
  logic wbStb;
  logic wbWe;
  logic [klClockPkg::adrWidth-1:0] wbAdr;
  logic [klClockPkg::dataWidth-1:0] wbDatW;
  logic [klClockPkg::dataWidth-1:0] wbDatR;
  logic wbAck;
  logic [klClockPkg::timeWidth-1:0] timeField;
  logic eboxSync;
  logic eboxClk;
  logic crmClk;
  logic edpClk;
  logic ctlClk;
  logic mrReset;

  logic [15:0] lfsrState;
  int timeoutCount;

  // Bounds on every wait loop
  localparam int ackLimit = 20;

  klClockTop u_dut (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbWe     (wbWe),
    .wbAdr    (wbAdr),
    .wbDatW   (wbDatW),
    .wbDatR   (wbDatR),
    .wbAck    (wbAck),
    .timeField(timeField),
    .eboxSync (eboxSync),
    .eboxClk  (eboxClk),
    .crmClk   (crmClk),
    .edpClk   (edpClk),
    .ctlClk   (ctlClk),
    .mrReset  (mrReset)
  );

  klClockChecker chk (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .eboxSync (eboxSync),
    .eboxClk  (eboxClk),
    .crmClk   (crmClk),
    .edpClk   (edpClk),
    .ctlClk   (ctlClk)
  );

  // 40 ns MBOX clock
  initial begin
    MBOX_CLK = 1'b0;
    forever begin
      #20 MBOX_CLK = ~MBOX_CLK;
    end
  end

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic randBits(input int n, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[6:0], lfsrState[15]};
    end
  endtask

  function automatic logic [3:0] ctlAdr(input logic [2:0] code);
    return {1'b0, code};
  endfunction

  function automatic logic [3:0] loadAdr(input logic [2:0] code);
    return {1'b1, code};
  endfunction

  // Larger of 2**rate and timeField+2
  function automatic int minGap(input logic [1:0] rate, input logic [1:0] tf);
    int rateGap;
    rateGap = 1 << rate;
    return (rateGap > int'(tf) + 2) ? rateGap : int'(tf) + 2;
  endfunction

  // Wishbone classic write, held until the ack cycle has passed
  task automatic busWrite(input logic [3:0] adr, input logic [7:0] data);
    int waited;
    waited = 0;
    @(negedge MBOX_CLK);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = 1'b1;
    wbAdr = adr;
    wbDatW = data;
    do begin
      @(negedge MBOX_CLK);
      waited++;
    end while (!wbAck && waited < ackLimit);
    if (!wbAck) begin
      timeoutCount++;
      $display("timeout: no wbAck for the write to address %h", adr);
    end
    @(negedge MBOX_CLK);
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
  endtask

  // Read data taken while wbAck is high
  task automatic busRead(input logic [3:0] adr, output logic [7:0] data);
    int waited;
    waited = 0;
    data = '0;
    @(negedge MBOX_CLK);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = 1'b0;
    wbAdr = adr;
    do begin
      @(negedge MBOX_CLK);
      waited++;
    end while (!wbAck && waited < ackLimit);
    if (wbAck) begin
      data = wbDatR;
    end else begin
      timeoutCount++;
      $display("timeout: no wbAck for the read from address %h", adr);
    end
    @(negedge MBOX_CLK);
    wbCyc = 1'b0;
    wbStb = 1'b0;
  endtask

  task automatic waitPulses(input int target, input int limit);
    int waited;
    waited = 0;
    while (chk.clkSince() < target && waited < limit) begin
      @(negedge MBOX_CLK);
      waited++;
    end
    if (chk.clkSince() < target) begin
      timeoutCount++;
      $display("timeout: only %0d of %0d processor clocks arrived", chk.clkSince(), target);
    end
  endtask

  task automatic resetTest();
    logic [7:0] rateRaw;
    logic [7:0] disRaw;
    logic [7:0] count;
    logic [7:0] rd;
    chk.beginTest("reset and readback", 0);
    chk.checkValue("clock outputs and ack after reset",
                   int'({wbAck, eboxSync, eboxClk, crmClk, edpClk, ctlClk}), 0);
    chk.checkValue("mrReset after reset", int'(mrReset), 1);
    busRead(ctlAdr(klClockPkg::rdStatus), rd);
    chk.checkValue("status after reset", int'(rd), int'(8'h04));
    // Upper bits of the load words are random and must be ignored
    randBits(8, rateRaw);
    randBits(8, disRaw);
    busWrite(loadAdr(klClockPkg::ldRate), rateRaw);
    busWrite(loadAdr(klClockPkg::ldDisable), disRaw);
    busRead(ctlAdr(klClockPkg::rdConfig), rd);
    chk.checkValue("config readback", int'(rd), int'({2'b00, rateRaw[1:0], 1'b0, disRaw[2:0]}));
    randBits(8, count);
    busWrite(loadAdr(klClockPkg::ldBurstLsb), {4'h0, count[3:0]});
    busWrite(loadAdr(klClockPkg::ldBurstMsb), {4'h0, count[7:4]});
    busRead(ctlAdr(klClockPkg::rdBurst), rd);
    chk.checkValue("burst count readback", int'(rd), int'(count));
    chk.endTest();
  endtask

  task automatic masterResetTest();
    logic [7:0] rd;
    chk.beginTest("master reset", 0);
    busWrite(ctlAdr(klClockPkg::funcStart), 8'h00);
    repeat (100) @(negedge MBOX_CLK);
    chk.checkPulses(0, 0, 0, 0);
    // Clearing reset also stops the run
    busWrite(ctlAdr(klClockPkg::funcClrReset), 8'h00);
    busRead(ctlAdr(klClockPkg::rdStatus), rd);
    chk.checkValue("mrReset and running after clrReset", int'({rd[2], rd[0]}), 0);
    busWrite(ctlAdr(klClockPkg::funcSetReset), 8'h00);
    busRead(ctlAdr(klClockPkg::rdStatus), rd);
    chk.checkValue("mrReset after setReset", int'(rd[2]), 1);
    chk.endTest();
  endtask

  // Burst of random length at a random rate and time field
  task automatic burstTest(input string name, input logic [2:0] dis);
    logic [7:0] count;
    logic [7:0] rate;
    logic [7:0] tf;
    logic [7:0] rd;
    int n;
    klClockPkg::diagWord_u word;
    randBits(8, count);
    if (count == 8'd0) count = 8'd1;
    randBits(2, rate);
    randBits(2, tf);
    n = int'(count);
    busWrite(ctlAdr(klClockPkg::funcClrReset), 8'h00);
    word = '0;
    word.rate.rateSel = rate[1:0];
    busWrite(loadAdr(klClockPkg::ldRate), word);
    word = '0;
    word.dis.crmDis = dis[2];
    word.dis.edpDis = dis[1];
    word.dis.ctlDis = dis[0];
    busWrite(loadAdr(klClockPkg::ldDisable), word);
    word = '0;
    word.nib.value = count[3:0];
    busWrite(loadAdr(klClockPkg::ldBurstLsb), word);
    word.nib.value = count[7:4];
    busWrite(loadAdr(klClockPkg::ldBurstMsb), word);
    timeField = tf[1:0];
    chk.beginTest(name, minGap(rate[1:0], tf[1:0]));
    busWrite(ctlAdr(klClockPkg::funcBurst), 8'h00);
    // The Nth processor clock ends the burst, at most 10 cycles apart
    waitPulses(n, n * 16 + 32);
    busRead(ctlAdr(klClockPkg::rdStatus), rd);
    chk.checkValue("running and bursting after burst", int'(rd[1:0]), 0);
    busRead(ctlAdr(klClockPkg::rdBurst), rd);
    chk.checkValue("burst count after burst", int'(rd), 0);
    chk.checkPulses(n, dis[2] ? 0 : n, dis[1] ? 0 : n, dis[0] ? 0 : n);
    chk.endTest();
  endtask

  task automatic singleStepTest();
    chk.beginTest("single step", 0);
    busWrite(ctlAdr(klClockPkg::funcSingleStep), 8'h00);
    waitPulses(1, 20);
    // Longer than the largest sync latency
    repeat (10) @(negedge MBOX_CLK);
    chk.checkPulses(1, 1, 1, 1);
    chk.endTest();
  endtask

  task automatic runTest();
    logic [7:0] rate;
    logic [7:0] tf;
    int stopBase;
    klClockPkg::diagWord_u word;
    randBits(2, rate);
    randBits(2, tf);
    word = '0;
    word.rate.rateSel = rate[1:0];
    busWrite(loadAdr(klClockPkg::ldRate), word);
    timeField = tf[1:0];
    chk.beginTest("run and stop", minGap(rate[1:0], tf[1:0]));
    busWrite(ctlAdr(klClockPkg::funcStart), 8'h00);
    waitPulses(4, 100);
    busWrite(ctlAdr(klClockPkg::funcClrReset), 8'h00);
    stopBase = chk.clkSince();
    repeat (40) @(negedge MBOX_CLK);
    chk.checkAtMost("pulses after stop", chk.clkSince() - stopBase, 1);
    chk.endTest();
  endtask

  initial begin
    logic [7:0] dis;
    CLK = 1'b1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatW = '0;
    timeField = '0;
    lfsrState = 16'd99;
    timeoutCount = 0;
    repeat (4) @(posedge MBOX_CLK);
    @(negedge MBOX_CLK);
    CLK = 1'b0;
    @(negedge MBOX_CLK);
    resetTest();
    masterResetTest();
    burstTest("burst", 3'b000);
    singleStepTest();
    runTest();
    randBits(3, dis);
    burstTest("domain enables", dis[2:0]);
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d timeouts",
             chk.testsRun, chk.testsFailed, chk.checks, chk.errorTotal(), timeoutCount);
    if (chk.errorTotal() == 0 && timeoutCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
